// ==== csr_pkg.sv ====
`default_nettype none

package csr_pkg;

  // **********************************************************************
  // sizes.
  // **********************************************************************

  localparam int NUM_HARTS  = 4;
  localparam int HART_W     = 2;
  localparam int CSR_ADDR_W = 12;
  localparam int XLEN       = 32;
  localparam int PADDR_W    = 16;

  // **********************************************************************
  // machine mode csr numbers.
  // **********************************************************************

  localparam logic [CSR_ADDR_W-1:0] csr_mstatus    = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] csr_misa       = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] csr_medeleg    = 12'h302;
  localparam logic [CSR_ADDR_W-1:0] csr_mideleg    = 12'h303;
  localparam logic [CSR_ADDR_W-1:0] csr_mie        = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] csr_mtvec      = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] csr_mcounteren = 12'h306;
  localparam logic [CSR_ADDR_W-1:0] csr_mscratch   = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] csr_mepc       = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] csr_mcause     = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] csr_mtval      = 12'h343;
  localparam logic [CSR_ADDR_W-1:0] csr_mip        = 12'h344;
  localparam logic [CSR_ADDR_W-1:0] csr_mcycle     = 12'hB00;
  localparam logic [CSR_ADDR_W-1:0] csr_minstret   = 12'hB02;
  localparam logic [CSR_ADDR_W-1:0] csr_mcycleh    = 12'hB80;
  localparam logic [CSR_ADDR_W-1:0] csr_minstreth  = 12'hB82;

  // trap stack bits in mstatus.
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  // mxl = 1 (rv32), extension i only.
  localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;

  // **********************************************************************
  // types.
  // **********************************************************************

  typedef struct packed {
    logic [XLEN-3:0] base;
    logic [1:0]      mode;
  } mtvec_t;

  typedef union packed {
    logic [XLEN-1:0] raw;
    mtvec_t          mtvec;
  } csr_word_u;

  typedef enum logic [1:0] {
    ev_none,
    ev_retire,
    ev_exception,
    ev_mret
  } event_kind_e;

  typedef struct packed {
    event_kind_e       kind;
    logic [HART_W-1:0] hart;
    logic [XLEN-1:0]   epc;
    logic [XLEN-1:0]   tval;
    logic [3:0]        cause;
  } hart_event_t;

  typedef struct packed {
    logic                  rden;
    logic                  wren;
    logic [CSR_ADDR_W-1:0] addr;
    csr_word_u             wdata;
  } csr_access_t;

  typedef struct packed {
    csr_word_u rdata;
    logic      hit;
  } csr_resp_t;

  // one hart's view of the event port.
  typedef struct packed {
    logic            retire;
    logic            exception;
    logic            mret;
    logic [XLEN-1:0] epc;
    logic [XLEN-1:0] tval;
    logic [3:0]      cause;
  } hart_trap_t;

  typedef struct packed {
    logic            exception;
    logic            mret;
    logic [XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic [HART_W-1:0] hart;
    logic              is_mret;
    logic [XLEN-1:0]   target;
  } redirect_out_t;

endpackage

`default_nettype wire

// ==== csr_hart_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_hart_router (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         psel,
  input  wire logic                         penable,
  input  wire logic                         pwrite,
  input  wire logic [csr_pkg::PADDR_W-1:0]  paddr,
  input  wire logic [csr_pkg::XLEN-1:0]     pwdata,
  output logic      [csr_pkg::XLEN-1:0]     prdata,
  output logic                              pready,
  output logic                              pslverr,
  input  csr_pkg::hart_event_t              hart_evt,
  output csr_pkg::csr_access_t              access [csr_pkg::NUM_HARTS],
  output csr_pkg::hart_trap_t               trap [csr_pkg::NUM_HARTS],
  input  csr_pkg::csr_resp_t                resp [csr_pkg::NUM_HARTS]
);

  logic                          setup_q;
  logic                          acc;
  logic [csr_pkg::HART_W-1:0]    hart_sel;

  // a setup cycle must precede the access cycle.
  always_ff @(posedge clk) begin
    if (!rst) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= psel & ~penable;
    end
  end

  assign acc      = psel & penable & setup_q;
  assign hart_sel = paddr[15:14];
  assign pready   = 1'b1;

  always_comb begin
    for (int h = 0; h < csr_pkg::NUM_HARTS; h++) begin
      access[h].rden        = acc & ~pwrite & (hart_sel == csr_pkg::HART_W'(h));
      access[h].wren        = acc & pwrite & (hart_sel == csr_pkg::HART_W'(h));
      access[h].addr        = paddr[13:2];
      access[h].wdata.raw   = pwdata;
    end
  end

  // read data from the addressed hart only.
  always_comb begin
    prdata  = '0;
    pslverr = 1'b0;
    if (acc) begin
      prdata  = resp[hart_sel].hit ? resp[hart_sel].rdata.raw : '0;
      pslverr = ~resp[hart_sel].hit;
    end
  end

  // **********************************************************************
  // event demultiplexer.
  // **********************************************************************

  always_comb begin
    for (int h = 0; h < csr_pkg::NUM_HARTS; h++) begin
      trap[h].retire    = (hart_evt.hart == csr_pkg::HART_W'(h)) &&
                          (hart_evt.kind == csr_pkg::ev_retire);
      trap[h].exception = (hart_evt.hart == csr_pkg::HART_W'(h)) &&
                          (hart_evt.kind == csr_pkg::ev_exception);
      trap[h].mret      = (hart_evt.hart == csr_pkg::HART_W'(h)) &&
                          (hart_evt.kind == csr_pkg::ev_mret);
      trap[h].epc       = hart_evt.epc;
      trap[h].tval      = hart_evt.tval;
      trap[h].cause     = hart_evt.cause;
    end
  end

endmodule

`default_nettype wire

// ==== csr.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr (
  input  wire logic            clk,
  input  wire logic            rst,
  input  csr_pkg::csr_access_t access,
  output csr_pkg::csr_resp_t   resp,
  input  csr_pkg::hart_trap_t  trap,
  output csr_pkg::redirect_t   redir
);

  logic [csr_pkg::XLEN-1:0] mstatus_q;
  logic [csr_pkg::XLEN-1:0] medeleg_q;
  logic [csr_pkg::XLEN-1:0] mideleg_q;
  logic [csr_pkg::XLEN-1:0] mie_q;
  csr_pkg::csr_word_u       mtvec_q;
  logic [csr_pkg::XLEN-1:0] mcounteren_q;
  logic [csr_pkg::XLEN-1:0] mscratch_q;
  logic [csr_pkg::XLEN-1:0] mepc_q;
  logic [csr_pkg::XLEN-1:0] mcause_q;
  logic [csr_pkg::XLEN-1:0] mtval_q;
  logic [csr_pkg::XLEN-1:0] mip_q;
  logic [63:0]              mcycle_q;
  logic [63:0]              minstret_q;

  logic                     exc_q;
  logic                     mret_q;
  logic [csr_pkg::XLEN-1:0] target_q;

  csr_pkg::csr_word_u       mtvec_nx;
  logic [csr_pkg::XLEN-1:0] mepc_nx;
  logic [csr_pkg::XLEN-1:0] vector;

  // **********************************************************************
  // read port.
  // **********************************************************************

  always_comb begin
    resp.hit       = 1'b1;
    resp.rdata.raw = '0;
    case (access.addr)
      csr_pkg::csr_mstatus    : resp.rdata.raw = mstatus_q;
      csr_pkg::csr_misa       : resp.rdata.raw = csr_pkg::MISA_VALUE;
      csr_pkg::csr_medeleg    : resp.rdata.raw = medeleg_q;
      csr_pkg::csr_mideleg    : resp.rdata.raw = mideleg_q;
      csr_pkg::csr_mie        : resp.rdata.raw = mie_q;
      csr_pkg::csr_mtvec      : resp.rdata     = mtvec_q;
      csr_pkg::csr_mcounteren : resp.rdata.raw = mcounteren_q;
      csr_pkg::csr_mscratch   : resp.rdata.raw = mscratch_q;
      csr_pkg::csr_mepc       : resp.rdata.raw = mepc_q;
      csr_pkg::csr_mcause     : resp.rdata.raw = mcause_q;
      csr_pkg::csr_mtval      : resp.rdata.raw = mtval_q;
      csr_pkg::csr_mip        : resp.rdata.raw = mip_q;
      csr_pkg::csr_mcycle     : resp.rdata.raw = mcycle_q[31:0];
      csr_pkg::csr_mcycleh    : resp.rdata.raw = mcycle_q[63:32];
      csr_pkg::csr_minstret   : resp.rdata.raw = minstret_q[31:0];
      csr_pkg::csr_minstreth  : resp.rdata.raw = minstret_q[63:32];
      default                 : resp.hit       = 1'b0;
    endcase
    if (!access.rden) begin
      resp.rdata.raw = '0;
    end
  end

  // mtvec and mepc as they stand after this edge's host write.
  always_comb begin
    mtvec_nx = mtvec_q;
    mepc_nx  = mepc_q;
    if (access.wren && access.addr == csr_pkg::csr_mtvec) begin
      mtvec_nx = access.wdata;
    end
    if (access.wren && access.addr == csr_pkg::csr_mepc) begin
      mepc_nx = access.wdata.raw;
    end
  end

  // vectored mode jumps to base + 4 * cause.
  assign vector = (mtvec_nx.mtvec.mode == 2'd1) ?
                  {mtvec_nx.mtvec.base + {{(csr_pkg::XLEN-6){1'b0}}, trap.cause}, 2'b00} :
                  {mtvec_nx.mtvec.base, 2'b00};

  // **********************************************************************
  // register update.
  // **********************************************************************

  always_ff @(posedge clk) begin
    if (!rst) begin
      mstatus_q    <= '0;
      medeleg_q    <= '0;
      mideleg_q    <= '0;
      mie_q        <= '0;
      mtvec_q      <= '0;
      mcounteren_q <= '0;
      mscratch_q   <= '0;
      mepc_q       <= '0;
      mcause_q     <= '0;
      mtval_q      <= '0;
      mip_q        <= '0;
      mcycle_q     <= '0;
      minstret_q   <= '0;
      exc_q        <= 1'b0;
      mret_q       <= 1'b0;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
      if (trap.retire) begin
        minstret_q <= minstret_q + 64'd1;
      end

      // host writes, after the counter increments so a write wins.
      if (access.wren) begin
        case (access.addr)
          csr_pkg::csr_mstatus    : mstatus_q        <= access.wdata.raw;
          csr_pkg::csr_medeleg    : medeleg_q        <= access.wdata.raw;
          csr_pkg::csr_mideleg    : mideleg_q        <= access.wdata.raw;
          csr_pkg::csr_mie        : mie_q            <= access.wdata.raw;
          csr_pkg::csr_mtvec      : mtvec_q          <= access.wdata;
          csr_pkg::csr_mcounteren : mcounteren_q     <= access.wdata.raw;
          csr_pkg::csr_mscratch   : mscratch_q       <= access.wdata.raw;
          csr_pkg::csr_mepc       : mepc_q           <= access.wdata.raw;
          csr_pkg::csr_mcause     : mcause_q         <= access.wdata.raw;
          csr_pkg::csr_mtval      : mtval_q          <= access.wdata.raw;
          csr_pkg::csr_mip        : mip_q            <= access.wdata.raw;
          csr_pkg::csr_mcycle     : mcycle_q[31:0]   <= access.wdata.raw;
          csr_pkg::csr_mcycleh    : mcycle_q[63:32]  <= access.wdata.raw;
          csr_pkg::csr_minstret   : minstret_q[31:0] <= access.wdata.raw;
          csr_pkg::csr_minstreth  : minstret_q[63:32] <= access.wdata.raw;
          default                 : ;
        endcase
      end

      // trap events override the host.
      if (trap.exception) begin
        mstatus_q[csr_pkg::MSTATUS_MPIE] <= mstatus_q[csr_pkg::MSTATUS_MIE];
        mstatus_q[csr_pkg::MSTATUS_MIE]  <= 1'b0;
        mepc_q   <= trap.epc;
        mtval_q  <= trap.tval;
        mcause_q <= {{(csr_pkg::XLEN-4){1'b0}}, trap.cause};
      end
      if (trap.mret) begin
        mstatus_q[csr_pkg::MSTATUS_MIE]  <= mstatus_q[csr_pkg::MSTATUS_MPIE];
        mstatus_q[csr_pkg::MSTATUS_MPIE] <= 1'b1;
      end

      exc_q  <= trap.exception;
      mret_q <= trap.mret;
    end
  end

  always_ff @(posedge clk) begin
    target_q <= trap.mret ? mepc_nx : vector;
  end

  assign redir.exception = exc_q;
  assign redir.mret      = mret_q;
  assign redir.target    = target_q;

endmodule

`default_nettype wire

// ==== redirect_collector.sv ====
`timescale 1ns/1ps
`default_nettype none

module redirect_collector (
  input  wire logic              clk,
  input  wire logic              rst,
  input  csr_pkg::redirect_t     redir [csr_pkg::NUM_HARTS],
  output csr_pkg::redirect_out_t redirect,
  output logic                   redirect_valid,
  input  wire logic              redirect_ready
);

  logic [csr_pkg::NUM_HARTS-1:0] pend_q;
  logic [csr_pkg::NUM_HARTS-1:0] mret_q;
  logic [csr_pkg::XLEN-1:0]      target_q [csr_pkg::NUM_HARTS];
  logic [csr_pkg::HART_W-1:0]    sel;
  logic                          take;

  // fixed priority, lowest hart first.
  always_comb begin
    sel = '0;
    for (int h = csr_pkg::NUM_HARTS - 1; h >= 0; h--) begin
      if (pend_q[h]) begin
        sel = csr_pkg::HART_W'(h);
      end
    end
  end

  assign redirect_valid   = |pend_q;
  assign redirect.hart    = sel;
  assign redirect.is_mret = mret_q[sel];
  assign redirect.target  = target_q[sel];
  assign take             = redirect_valid & redirect_ready;

  always_ff @(posedge clk) begin
    if (!rst) begin
      pend_q <= '0;
      mret_q <= '0;
    end else begin
      for (int h = 0; h < csr_pkg::NUM_HARTS; h++) begin
        // a fresh pulse replaces whatever is waiting.
        if (redir[h].exception || redir[h].mret) begin
          pend_q[h] <= 1'b1;
          mret_q[h] <= redir[h].mret;
        end else if (take && sel == csr_pkg::HART_W'(h)) begin
          pend_q[h] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int h = 0; h < csr_pkg::NUM_HARTS; h++) begin
      if (redir[h].exception || redir[h].mret) begin
        target_q[h] <= redir[h].target;
      end
    end
  end

endmodule

`default_nettype wire

// ==== csr_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_cluster (
  input  wire logic                         clk,
  input  wire logic                         rst,
  input  wire logic                         psel,
  input  wire logic                         penable,
  input  wire logic                         pwrite,
  input  wire logic [csr_pkg::PADDR_W-1:0]  paddr,
  input  wire logic [csr_pkg::XLEN-1:0]     pwdata,
  output logic      [csr_pkg::XLEN-1:0]     prdata,
  output logic                              pready,
  output logic                              pslverr,
  input  csr_pkg::hart_event_t              hart_evt,
  output csr_pkg::redirect_out_t            redirect,
  output logic                              redirect_valid,
  input  wire logic                         redirect_ready
);

  csr_pkg::csr_access_t access [csr_pkg::NUM_HARTS];
  csr_pkg::hart_trap_t  trap   [csr_pkg::NUM_HARTS];
  csr_pkg::csr_resp_t   resp   [csr_pkg::NUM_HARTS];
  csr_pkg::redirect_t   redir  [csr_pkg::NUM_HARTS];

  csr_hart_router u_router (
    .clk      (clk),
    .rst      (rst),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .hart_evt (hart_evt),
    .access   (access),
    .trap     (trap),
    .resp     (resp)
  );

  // one csr file per hart.
  for (genvar g = 0; g < csr_pkg::NUM_HARTS; g++) begin : g_hart
    csr u_csr (
      .clk    (clk),
      .rst    (rst),
      .access (access[g]),
      .resp   (resp[g]),
      .trap   (trap[g]),
      .redir  (redir[g])
    );
  end

  redirect_collector u_collector (
    .clk            (clk),
    .rst            (rst),
    .redir          (redir),
    .redirect       (redirect),
    .redirect_valid (redirect_valid),
    .redirect_ready (redirect_ready)
  );

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst
);

  // 4 ns period.
  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // active low for 5 cycles, released just after an edge.
  initial begin
    rst = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst = 1'b1;
  end

endmodule

`default_nettype wire

// ==== csr_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csr_cluster_tb;

  localparam int NUM_OPS    = 2000;
  localparam int MAX_CYCLES = 40 * NUM_OPS;
  localparam int NH         = csr_pkg::NUM_HARTS;

  logic                          clk;
  logic                          rst;
  logic                          psel;
  logic                          penable;
  logic                          pwrite;
  logic [csr_pkg::PADDR_W-1:0]   paddr;
  logic [csr_pkg::XLEN-1:0]      pwdata;
  logic [csr_pkg::XLEN-1:0]      prdata;
  logic                          pready;
  logic                          pslverr;
  csr_pkg::hart_event_t          hart_evt;
  csr_pkg::redirect_out_t        redirect;
  logic                          redirect_valid;
  logic                          redirect_ready;

  // standard csr numbers, in the slot order of the model.
  logic [11:0] csr_addr [16] = '{12'h300, 12'h301, 12'h302, 12'h303, 12'h304, 12'h305,
                                 12'h306, 12'h340, 12'h341, 12'h342, 12'h343, 12'h344,
                                 12'hB00, 12'hB80, 12'hB02, 12'hB82};

  // **********************************************************************
  // reference model state.
  // **********************************************************************

  logic [31:0] mreg [NH][12];
  logic [63:0] mcyc [NH];
  logic [63:0] minst [NH];
  logic        pulse_v [NH];
  logic        pulse_mret [NH];
  logic [31:0] pulse_tgt [NH];
  logic        pend_v [NH];
  logic        pend_mret [NH];
  logic [31:0] pend_tgt [NH];
  logic        ready_low;
  int          cycles = 0;

  tb_clock_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  csr_cluster DUT (
    .clk            (clk),
    .rst            (rst),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .pready         (pready),
    .pslverr        (pslverr),
    .hart_evt       (hart_evt),
    .redirect       (redirect),
    .redirect_valid (redirect_valid),
    .redirect_ready (redirect_ready)
  );

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input csr_pkg::csr_word_u exp,
                            input csr_pkg::csr_word_u act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %h actual %h", name, exp.raw, act.raw));
    end
  endtask

  task automatic check_redirect(input string name, input csr_pkg::redirect_out_t exp,
                                input csr_pkg::redirect_out_t act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_err(input string name, input bit exp, input bit act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("Mismatch %s: expected %b actual %b", name, exp, act));
    end
  endtask

  function automatic int slot_of(input logic [11:0] addr);
    for (int i = 0; i < 16; i++) begin
      if (csr_addr[i] == addr) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic logic [31:0] model_read(input int h, input int s);
    case (s)
      -1: return 32'd0;
      1: return csr_pkg::MISA_VALUE;
      12: return mcyc[h][31:0];
      13: return mcyc[h][63:32];
      14: return minst[h][31:0];
      15: return minst[h][63:32];
      default: return mreg[h][s];
    endcase
  endfunction

  task automatic model_write(input int h, input int s, input logic [31:0] data);
    case (s)
      -1, 1: ;
      12: mcyc[h][31:0] = data;
      13: mcyc[h][63:32] = data;
      14: minst[h][31:0] = data;
      15: minst[h][63:32] = data;
      default: mreg[h][s] = data;
    endcase
  endtask

  task automatic drive_random();
    int k;
    k = $urandom_range(0, 19);
    hart_evt.kind  = (k < 8) ? csr_pkg::ev_none : (k < 14) ? csr_pkg::ev_retire :
                     (k < 17) ? csr_pkg::ev_exception : csr_pkg::ev_mret;
    hart_evt.hart  = csr_pkg::HART_W'($urandom_range(0, NH - 1));
    hart_evt.epc   = $urandom;
    hart_evt.tval  = $urandom;
    hart_evt.cause = 4'($urandom);
    redirect_ready = ready_low ? 1'b0 : 1'($urandom);
  endtask

  // checks outputs before the edge, then advances the model across it.
  task automatic step();
    int                     h;
    int                     s;
    int                     e;
    int                     sel;
    logic [31:0]            old_ms;
    logic [31:0]            mt;
    csr_pkg::csr_word_u     exp_w;
    csr_pkg::csr_word_u     act_w;
    csr_pkg::redirect_out_t exp_r;
    #2;
    h = int'(paddr[15:14]);
    s = slot_of(paddr[13:2]);
    check_valid("pready", 1'b1, pready);
    if (psel && penable) begin
      check_err("pslverr", s < 0, pslverr);
      if (!pwrite) begin
        exp_w.raw = model_read(h, s);
        act_w.raw = prdata;
        check_word($sformatf("read hart %0d csr %h", h, paddr[13:2]), exp_w, act_w);
      end
    end else begin
      exp_w.raw = '0;
      act_w.raw = prdata;
      check_err("idle pslverr", 1'b0, pslverr);
      check_word("idle prdata", exp_w, act_w);
    end
    sel = -1;
    for (int i = NH - 1; i >= 0; i--) begin
      if (pend_v[i]) begin
        sel = i;
      end
    end
    check_valid("redirect_valid", sel >= 0, redirect_valid);
    if (sel >= 0) begin
      exp_r.hart    = csr_pkg::HART_W'(sel);
      exp_r.is_mret = pend_mret[sel];
      exp_r.target  = pend_tgt[sel];
      check_redirect("redirect", exp_r, redirect);
    end
    @(posedge clk);
    for (int i = 0; i < NH; i++) begin
      if (pulse_v[i]) begin
        pend_v[i]    = 1'b1;
        pend_mret[i] = pulse_mret[i];
        pend_tgt[i]  = pulse_tgt[i];
      end else if (redirect_ready && sel == i) begin
        pend_v[i] = 1'b0;
      end
      pulse_v[i] = 1'b0;
      mcyc[i]    = mcyc[i] + 64'd1;
    end
    e      = int'(hart_evt.hart);
    old_ms = mreg[e][0];
    if (hart_evt.kind == csr_pkg::ev_retire) begin
      minst[e] = minst[e] + 64'd1;
    end
    if (psel && penable && pwrite) begin
      model_write(h, s, pwdata);
    end
    if (hart_evt.kind == csr_pkg::ev_exception) begin
      mreg[e][0][csr_pkg::MSTATUS_MPIE] = old_ms[csr_pkg::MSTATUS_MIE];
      mreg[e][0][csr_pkg::MSTATUS_MIE]  = 1'b0;
      mreg[e][8]  = hart_evt.epc;
      mreg[e][10] = hart_evt.tval;
      mreg[e][9]  = {28'd0, hart_evt.cause};
      mt = mreg[e][5];
      pulse_v[e]    = 1'b1;
      pulse_mret[e] = 1'b0;
      pulse_tgt[e]  = (mt & 32'hffff_fffc) +
                      ((mt[1:0] == 2'd1) ? {26'd0, hart_evt.cause, 2'b00} : 32'd0);
    end else if (hart_evt.kind == csr_pkg::ev_mret) begin
      mreg[e][0][csr_pkg::MSTATUS_MIE]  = old_ms[csr_pkg::MSTATUS_MPIE];
      mreg[e][0][csr_pkg::MSTATUS_MPIE] = 1'b1;
      pulse_v[e]    = 1'b1;
      pulse_mret[e] = 1'b1;
      pulse_tgt[e]  = mreg[e][8];
    end
    #1;
  endtask

  // one apb transfer, setup then access, with events running alongside.
  task automatic apb_op();
    logic [1:0]  h;
    logic [11:0] addr;
    h = 2'($urandom_range(0, NH - 1));
    if ($urandom_range(0, 7) == 0) begin
      addr = 12'($urandom);
    end else begin
      addr = csr_addr[$urandom_range(0, 15)];
    end
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'($urandom);
    paddr   = {h, addr, 2'($urandom)};
    pwdata  = $urandom;
    drive_random();
    step();
    penable = 1'b1;
    drive_random();
    step();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  function automatic bit redirects_left();
    for (int i = 0; i < NH; i++) begin
      if (pend_v[i] || pulse_v[i]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      abort_run("timeout: the run did not finish within its cycle limit");
    end
  end

  // **********************************************************************
  // main sequence.
  // **********************************************************************

  initial begin
    void'($urandom(32'h2afe846e));
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    hart_evt       = '0;
    redirect_ready = 1'b0;
    ready_low      = 1'b0;
    for (int h = 0; h < NH; h++) begin
      for (int i = 0; i < 12; i++) begin
        mreg[h][i] = '0;
      end
      mcyc[h]    = '0;
      minst[h]   = '0;
      pulse_v[h] = 1'b0;
      pend_v[h]  = 1'b0;
    end
    wait (rst === 1'b1);
    for (int op = 0; op < NUM_OPS; op++) begin
      // every fourth block of ops stalls the redirect consumer.
      ready_low = ((op / 100) % 4) == 3;
      if ($urandom_range(0, 3) == 0) begin
        drive_random();
        step();
      end else begin
        apb_op();
      end
    end
    // drain what is still pending.
    while (redirects_left()) begin
      hart_evt       = '0;
      redirect_ready = 1'b1;
      step();
    end
    step();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
csr_pkg.sv
csr_hart_router.sv
csr.sv
redirect_collector.sv
csr_cluster.sv
tb_clock_gen.sv
csr_cluster_tb.sv

// ==== Makefile ====
TOP := csr_cluster_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --timescale 1ns/1ps -f sources.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/1ps -f sources.f \
		--top-module csr_cluster

clean:
	rm -rf obj_dir $(LOG)
